//--- design/cpuPkg.sv
`default_nettype none

package cpuPkg;

	typedef logic [31:0] wordT;
	typedef logic [3:0] regIdxT;

	// instruction encodings, top five bits of the word
	typedef enum logic [4:0] {
		opAdd  = 5'b00011,
		opSub  = 5'b00100,
		opShr  = 5'b00101,
		opShl  = 5'b00110,
		opRor  = 5'b00111,
		opRol  = 5'b01000,
		opAnd  = 5'b01001,
		opOr   = 5'b01010,
		opAddi = 5'b01011,
		opAndi = 5'b01100,
		opOri  = 5'b01101,
		opNeg  = 5'b10000,
		opNot  = 5'b10001,
		opNop  = 5'b11001,
		opHalt = 5'b11010
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluShr,
		aluShl, aluRor, aluRol, aluNeg, aluNot
	} aluOpT;

	// immediate is bits 18..0, so it overlaps rc
	typedef struct packed {
		opcodeT      opcode;
		regIdxT      ra;
		regIdxT      rb;
		regIdxT      rc;
		logic [14:0] filler;
	} instrT;

	typedef struct packed {
		aluOpT aluOp;
		logic  useImm;
		wordT  imm; // already sign-extended
	} execCmdT;

	typedef struct packed {
		regIdxT ra;
		wordT   value;
	} resultT;

endpackage

`default_nettype wire

//--- design/instrQueue.sv
`timescale 1ns/1ps
`default_nettype none

module instrQueue import cpuPkg::*; #(
	parameter int QueueDepth = 4
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  instrValid,
	input  instrT instr,
	input  logic  pop,
	output logic  notEmpty,
	output instrT headInstr,
	output logic  instrCredit
);

	localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
	localparam int CountWidth = $clog2(QueueDepth + 1);
	localparam logic [PtrWidth-1:0] LastSlot = PtrWidth'(QueueDepth - 1);

	instrT mem [QueueDepth];
	logic [PtrWidth-1:0] wrPtr, rdPtr;
	logic [CountWidth-1:0] count;
	logic full, push, popEn;

	assign full = (count == CountWidth'(QueueDepth));
	assign notEmpty = (count != '0);
	assign push = instrValid && !full;
	assign popEn = pop && notEmpty;
	assign headInstr = mem[rdPtr];
	assign instrCredit = popEn; // slot freed, hand credit back

	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= instr;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == LastSlot) ? '0 : wrPtr + 1'b1;
			if (popEn)
				rdPtr <= (rdPtr == LastSlot) ? '0 : rdPtr + 1'b1;
			if (push && !popEn)
				count <= count + 1'b1;
			else if (popEn && !push)
				count <= count - 1'b1;
		end
	end

	// source must hold a credit for every word it sends
	assert property (@(posedge clk) disable iff (reset) instrValid |-> !full);

endmodule

`default_nettype wire

//--- design/controlDecode.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecode import cpuPkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    notEmpty,
	input  instrT   headInstr,
	output logic    pop,
	output logic    loadY,
	output logic    loadZ,
	output execCmdT execCmd,
	output regIdxT  rbIdx,
	output regIdxT  rcIdx,
	output regIdxT  wbIdx,
	output logic    commit,
	input  logic    wbDone,
	output logic    halted
);

	typedef enum logic [2:0] {
		stIdle, stOperand, stExecute, stWriteback, stHalt
	} stateT;

	stateT state, nextState;
	instrT ir;
	logic [18:0] immBits;

	assign pop = (state == stIdle) && notEmpty;
	assign loadY = (state == stOperand);
	assign loadZ = (state == stExecute);
	assign commit = (state == stWriteback);
	assign halted = (state == stHalt);

	assign rbIdx = ir.rb;
	assign rcIdx = ir.rc;
	assign wbIdx = ir.ra;
	assign immBits = {ir.rc, ir.filler};

	always_comb begin
		nextState = state;
		case (state)
			stIdle: begin
				if (pop) begin
					case (headInstr.opcode)
						opAdd, opSub, opAnd, opOr, opShr, opShl, opRor, opRol,
						opNeg, opNot, opAddi, opAndi, opOri:
							nextState = stOperand;
						opHalt: nextState = stHalt;
						default: nextState = stIdle; // nop and unused codes
					endcase
				end
			end
			stOperand: nextState = stExecute;
			stExecute: nextState = stWriteback;
			stWriteback: begin
				if (wbDone)
					nextState = stIdle;
			end
			stHalt: nextState = stHalt; // only reset leaves
			default: nextState = stIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= stIdle;
		else
			state <= nextState;
	end

	always_ff @(posedge clk) begin
		if (pop)
			ir <= headInstr;
	end

	// opcode to alu operation
	always_comb begin
		execCmd.useImm = 1'b0;
		execCmd.imm = {{13{immBits[18]}}, immBits};
		case (ir.opcode)
			opSub: execCmd.aluOp = aluSub;
			opAnd: execCmd.aluOp = aluAnd;
			opOr:  execCmd.aluOp = aluOr;
			opShr: execCmd.aluOp = aluShr;
			opShl: execCmd.aluOp = aluShl;
			opRor: execCmd.aluOp = aluRor;
			opRol: execCmd.aluOp = aluRol;
			opNeg: execCmd.aluOp = aluNeg;
			opNot: execCmd.aluOp = aluNot;
			opAddi: begin
				execCmd.aluOp = aluAdd;
				execCmd.useImm = 1'b1;
			end
			opAndi: begin
				execCmd.aluOp = aluAnd;
				execCmd.useImm = 1'b1;
			end
			opOri: begin
				execCmd.aluOp = aluOr;
				execCmd.useImm = 1'b1;
			end
			default: execCmd.aluOp = aluAdd;
		endcase
	end

	// write handshake only answers a pending commit
	assert property (@(posedge clk) disable iff (reset) wbDone |-> commit);

endmodule

`default_nettype wire

//--- design/aluExecute.sv
`timescale 1ns/1ps
`default_nettype none

module aluExecute import cpuPkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    loadY,
	input  logic    loadZ,
	input  execCmdT execCmd,
	input  wordT    rbData,
	input  wordT    rcData,
	output wordT    zValue
);

	wordT yReg, zReg;
	wordT opB, aluOut;
	logic [4:0] shamt;

	assign opB = execCmd.useImm ? execCmd.imm : rcData;
	assign shamt = opB[4:0];
	assign zValue = zReg;

	always_comb begin
		case (execCmd.aluOp)
			aluAdd: aluOut = yReg + opB;
			aluSub: aluOut = yReg - opB;
			aluAnd: aluOut = yReg & opB;
			aluOr:  aluOut = yReg | opB;
			aluShr: aluOut = yReg >> shamt; // logical
			aluShl: aluOut = yReg << shamt;
			aluRor: aluOut = (yReg >> shamt) | (yReg << (6'd32 - {1'b0, shamt}));
			aluRol: aluOut = (yReg << shamt) | (yReg >> (6'd32 - {1'b0, shamt}));
			aluNeg: aluOut = -yReg;
			aluNot: aluOut = ~yReg;
			default: aluOut = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (loadY)
			yReg <= rbData;
	end

	always_ff @(posedge clk) begin
		if (reset)
			zReg <= '0;
		else if (loadZ)
			zReg <= aluOut;
	end

endmodule

`default_nettype wire

//--- design/regFileResult.sv
`timescale 1ns/1ps
`default_nettype none

module regFileResult import cpuPkg::*; #(
	parameter int CreditWidth = 4
) (
	input  logic   clk,
	input  logic   reset,
	input  regIdxT rbIdx,
	input  regIdxT rcIdx,
	output wordT   rbData,
	output wordT   rcData,
	input  logic   commit,
	input  regIdxT wbIdx,
	input  wordT   zValue,
	output logic   wbDone,
	input  logic   resultCredit,
	output logic   resultValid,
	output resultT result
);

	localparam logic [CreditWidth-1:0] CreditMax = '1;

	wordT regs [16];
	logic [CreditWidth-1:0] creditCount;

	assign rbData = regs[rbIdx];
	assign rcData = regs[rcIdx];

	// write and emit only with a granted credit in hand
	assign wbDone = commit && (creditCount != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wbDone) begin
			regs[wbIdx] <= zValue;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			creditCount <= '0;
		else if (resultCredit && !wbDone && creditCount != CreditMax)
			creditCount <= creditCount + CreditWidth'(1);
		else if (wbDone && !resultCredit)
			creditCount <= creditCount - CreditWidth'(1);
	end

	always_ff @(posedge clk) begin
		if (reset)
			resultValid <= 1'b0;
		else
			resultValid <= wbDone;
	end

	always_ff @(posedge clk) begin
		if (wbDone)
			result <= '{ra: wbIdx, value: zValue};
	end

	// one write per commit, so no result goes out twice
	assert property (@(posedge clk) disable iff (reset) wbDone |=> !commit);

endmodule

`default_nettype wire

//--- design/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore import cpuPkg::*; #(
	parameter int QueueDepth = 4,
	parameter int CreditWidth = 4
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   instrValid,
	input  instrT  instr,
	output logic   instrCredit,
	input  logic   resultCredit,
	output logic   resultValid,
	output resultT result,
	output logic   halted
);

	instrT headInstr;
	logic notEmpty, pop;
	logic loadY, loadZ, commit, wbDone;
	execCmdT execCmd;
	regIdxT rbIdx, rcIdx, wbIdx;
	wordT rbData, rcData, zValue;

	instrQueue #(.QueueDepth(QueueDepth)) u_instrQueue (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.pop(pop),
		.notEmpty(notEmpty),
		.headInstr(headInstr),
		.instrCredit(instrCredit)
	);

	controlDecode u_controlDecode (
		.clk(clk),
		.reset(reset),
		.notEmpty(notEmpty),
		.headInstr(headInstr),
		.pop(pop),
		.loadY(loadY),
		.loadZ(loadZ),
		.execCmd(execCmd),
		.rbIdx(rbIdx),
		.rcIdx(rcIdx),
		.wbIdx(wbIdx),
		.commit(commit),
		.wbDone(wbDone),
		.halted(halted)
	);

	aluExecute u_aluExecute (
		.clk(clk),
		.reset(reset),
		.loadY(loadY),
		.loadZ(loadZ),
		.execCmd(execCmd),
		.rbData(rbData),
		.rcData(rcData),
		.zValue(zValue)
	);

	regFileResult #(.CreditWidth(CreditWidth)) u_regFileResult (
		.clk(clk),
		.reset(reset),
		.rbIdx(rbIdx),
		.rcIdx(rcIdx),
		.rbData(rbData),
		.rcData(rcData),
		.commit(commit),
		.wbIdx(wbIdx),
		.zValue(zValue),
		.wbDone(wbDone),
		.resultCredit(resultCredit),
		.resultValid(resultValid),
		.result(result)
	);

endmodule

`default_nettype wire

//--- bench/tbVectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: instruction word, result expected, destination index, destination value
// values follow from the register rules, starting with all registers zero
typedef struct packed {
	instrT  instr;
	logic   expValid;
	regIdxT expRa;
	wordT   expValue;
} vectorT;

localparam int NumVectors = 20;

vectorT vectors [NumVectors];

function automatic instrT encR(opcodeT op, regIdxT dst, regIdxT srcB, regIdxT srcC);
	instrT word;
	word.opcode = op;
	word.ra = dst;
	word.rb = srcB;
	word.rc = srcC;
	word.filler = '0;
	return word;
endfunction

function automatic instrT encI(opcodeT op, regIdxT dst, regIdxT srcB, logic [18:0] imm);
	return {op, dst, srcB, imm};
endfunction

function automatic vectorT row(instrT word, logic valid, regIdxT dst, wordT value);
	vectorT v;
	v.instr = word;
	v.expValid = valid;
	v.expRa = dst;
	v.expValue = value;
	return v;
endfunction

task automatic loadVectors();
	vectors[0] = row(encI(opAddi, 4'd1, 4'd0, 19'h00123), 1'b1, 4'd1, 32'h0000_0123);
	vectors[1] = row(encI(opAddi, 4'd2, 4'd0, 19'h7FFFB), 1'b1, 4'd2, 32'hFFFF_FFFB);
	vectors[2] = row(encR(opAdd, 4'd3, 4'd1, 4'd2), 1'b1, 4'd3, 32'h0000_011E);
	vectors[3] = row(encR(opSub, 4'd4, 4'd1, 4'd2), 1'b1, 4'd4, 32'h0000_0128);
	vectors[4] = row(encR(opAnd, 4'd5, 4'd2, 4'd3), 1'b1, 4'd5, 32'h0000_011A);
	vectors[5] = row(encR(opOr, 4'd6, 4'd1, 4'd4), 1'b1, 4'd6, 32'h0000_012B);
	vectors[6] = row(encI(opAddi, 4'd7, 4'd0, 19'h00004), 1'b1, 4'd7, 32'h0000_0004);
	vectors[7] = row(encR(opShr, 4'd8, 4'd2, 4'd7), 1'b1, 4'd8, 32'h0FFF_FFFF);
	vectors[8] = row(encR(opShl, 4'd9, 4'd1, 4'd7), 1'b1, 4'd9, 32'h0000_1230);
	vectors[9] = row(encR(opRor, 4'd10, 4'd1, 4'd7), 1'b1, 4'd10, 32'h3000_0012);
	vectors[10] = row(encR(opRol, 4'd11, 4'd2, 4'd7), 1'b1, 4'd11, 32'hFFFF_FFBF);
	vectors[11] = row(encR(opNeg, 4'd12, 4'd1, 4'd0), 1'b1, 4'd12, 32'hFFFF_FEDD);
	vectors[12] = row(encR(opNot, 4'd13, 4'd6, 4'd0), 1'b1, 4'd13, 32'hFFFF_FED4);
	vectors[13] = row(encR(opNop, 4'd0, 4'd0, 4'd0), 1'b0, 4'd0, 32'h0);
	vectors[14] = row(encI(opAndi, 4'd14, 4'd8, 19'h7FF00), 1'b1, 4'd14, 32'h0FFF_FF00);
	vectors[15] = row(encI(opOri, 4'd15, 4'd1, 19'h40000), 1'b1, 4'd15, 32'hFFFC_0123);
	vectors[16] = row(encR(opRor, 4'd3, 4'd6, 4'd0), 1'b1, 4'd3, 32'h0000_012B); // rotate by 0
	vectors[17] = row(encR(opHalt, 4'd0, 4'd0, 4'd0), 1'b0, 4'd0, 32'h0);
	vectors[18] = row(encI(opAddi, 4'd1, 4'd0, 19'h00055), 1'b0, 4'd0, 32'h0); // after halt
	vectors[19] = row(encR(opOr, 4'd2, 4'd1, 4'd1), 1'b0, 4'd0, 32'h0);
endtask

`endif

//--- bench/tbCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbCore import cpuPkg::*; ();

	localparam int QueueDepth = 4;
	localparam int CreditWidth = 4;
	localparam int ClkHalf = 50;
	localparam int NumRandom = 8;
	localparam int StallCycles = 24;
	localparam int HoldCycles = 30;
	localparam int WaitLimit = 2000;

	logic clk, reset, instrValid, instrCredit, resultCredit, resultValid, halted;
	instrT instr;
	resultT result;

	`include "tbVectors.svh"

	instrT sendList [$];
	resultT expList [$];
	wordT modelRegs [16];
	int haltPos = 0;
	int tableResults = 0;
	int spent = 0;
	int returned = 0;
	int granted = 0;
	int seen = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int mark = 0;
	logic haltSeen = 1'b0;

	cpuCore #(.QueueDepth(QueueDepth), .CreditWidth(CreditWidth)) u_cpuCore (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.instrCredit(instrCredit),
		.resultCredit(resultCredit),
		.resultValid(resultValid),
		.result(result),
		.halted(halted)
	);

	initial clk = 1'b0;
	always #(ClkHalf) clk = ~clk;

	task automatic checkFlag(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkResult(string name, resultT got, resultT exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got ra %h value %h, expected ra %h value %h",
				name, got.ra, got.value, exp.ra, exp.value);
		end
	endtask

	task automatic checkCount(string name, int got, int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("ERROR %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic endTest(string name);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == mark) ? "ok" : "FAILED");
		mark = errors;
	endtask

	task automatic abortRun(string why);
		$display("%s", why);
		$display("Test failures found");
		$finish;
	endtask

	// upper bits copy the immediate's sign bit
	function automatic wordT signExtend19(logic [18:0] imm);
		wordT ext;
		ext = {13'h0, imm};
		if (imm[18])
			ext[31:19] = '1;
		return ext;
	endfunction

	// random addi words go in just before the halt
	task automatic buildStimulus();
		logic [31:0] rnd;
		regIdxT dst, srcB;
		logic [18:0] imm;
		resultT exp;
		loadVectors();
		foreach (modelRegs[i])
			modelRegs[i] = '0;
		for (int i = 0; i < NumVectors; i++) begin
			if (vectors[i].instr.opcode == opHalt) begin
				tableResults = expList.size();
				for (int k = 0; k < NumRandom; k++) begin
					rnd = $urandom();
					dst = rnd[3:0];
					srcB = rnd[7:4];
					imm = rnd[26:8];
					exp.ra = dst;
					exp.value = modelRegs[srcB] + signExtend19(imm);
					modelRegs[dst] = exp.value;
					sendList.push_back(encI(opAddi, dst, srcB, imm));
					expList.push_back(exp);
				end
				haltPos = sendList.size();
			end
			sendList.push_back(vectors[i].instr);
			if (vectors[i].expValid) begin
				exp.ra = vectors[i].expRa;
				exp.value = vectors[i].expValue;
				modelRegs[exp.ra] = exp.value;
				expList.push_back(exp);
			end
		end
	endtask

	task automatic sendAll();
		int idx;
		int cycles;
		idx = 0;
		cycles = 0;
		while (idx < sendList.size()) begin
			@(posedge clk);
			if (QueueDepth + returned - spent > 0) begin // source holds a credit
				instrValid <= 1'b1;
				instr <= sendList[idx];
				spent++;
				idx++;
			end else begin
				instrValid <= 1'b0;
			end
			cycles++;
			if (cycles > WaitLimit)
				abortRun("instruction source never got its credits back");
		end
		@(posedge clk);
		instrValid <= 1'b0;
	endtask

	task automatic grantCredits(int total);
		int given;
		int gap;
		int cycles;
		given = 0;
		gap = 0;
		cycles = 0;
		while (given < total) begin
			@(posedge clk);
			resultCredit <= 1'b0;
			if (gap > 0) begin
				gap--;
			end else if (granted - seen < 8) begin // keep well below counter max
				resultCredit <= 1'b1;
				granted++;
				given++;
				gap = $urandom_range(3, 0);
			end
			cycles++;
			if (cycles > WaitLimit)
				abortRun("result credits were not taken up in time");
		end
		@(posedge clk);
		resultCredit <= 1'b0;
	endtask

	task automatic waitResults(int target);
		int cycles;
		cycles = 0;
		while (seen < target) begin
			@(negedge clk);
			cycles++;
			if (cycles > WaitLimit)
				abortRun("results stopped arriving before the expected count");
		end
	endtask

	task automatic waitHalted();
		int cycles;
		cycles = 0;
		while (!halted) begin
			@(negedge clk);
			cycles++;
			if (cycles > WaitLimit)
				abortRun("core never reached the halted state");
		end
	endtask

	// outputs sampled mid-cycle
	always @(negedge clk) begin
		if (!reset) begin
			if (instrCredit)
				returned++;
			if (resultValid) begin
				seen++;
				if (seen > granted) begin
					errors++;
					$display("result %0d came out without a granted credit", seen);
				end
				if (seen > expList.size()) begin
					errors++;
					$display("extra result %0d appeared beyond the expected stream", seen);
				end else begin
					checkResult($sformatf("result[%0d]", seen - 1), result, expList[seen - 1]);
				end
			end
			if (haltSeen && !halted) begin
				errors++;
				$display("halted dropped low before reset");
			end
			if (halted)
				haltSeen = 1'b1;
		end
	end

	initial begin
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		resultCredit = 1'b0;
		void'($urandom(67));
		buildStimulus();
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkFlag("resultValid", resultValid, 1'b0);
		checkFlag("instrCredit", instrCredit, 1'b0);
		checkFlag("halted", halted, 1'b0);
		endTest("reset state");

		fork
			sendAll();
			begin
				repeat (StallCycles) @(posedge clk); // withhold result credits
				@(negedge clk);
				checkCount("results without credit", seen, 0);
				checkCount("pops while stalled", returned, 1);
				checkCount("words sent while stalled", spent, QueueDepth + 1);
				endTest("stall without result credits");
				grantCredits(expList.size() + 2); // two spare credits for after halt
			end
		join

		waitResults(tableResults);
		endTest("table results in order");
		waitResults(expList.size());
		checkCount("results", seen, expList.size());
		endTest("random addi under back-pressure");

		waitHalted();
		repeat (HoldCycles) @(posedge clk);
		@(negedge clk);
		checkFlag("halted", halted, 1'b1);
		checkCount("instrCredit pulses", returned, haltPos + 1);
		checkCount("results after halt", seen, expList.size());
		checkCount("words sent", spent, sendList.size());
		endTest("halt and credit return");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+bench
design/cpuPkg.sv
design/instrQueue.sv
design/controlDecode.sv
design/aluExecute.sv
design/regFileResult.sv
design/cpuCore.sv
bench/tbCore.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbCore
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS     = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
